// File: Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - fetch.sv
  - register_file.sv
  - decode.sv
  - forwarding.sv
  - execute.sv
  - cpu.sv
  - target: simulation
    files:
      - tb_cpu.sv

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             instr_valid,
    input  wire [cpu_pkg::xlen-1:0]         instr,
    output logic                            wb_valid,
    output logic [cpu_pkg::xlen-1:0]        wb_pc,
    output logic [cpu_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [cpu_pkg::xlen-1:0]        wb_data
);

    ////////////////////
    // fetch to decode
    logic                           fe_valid;
    logic [cpu_pkg::xlen-1:0]       fe_instr;
    logic [cpu_pkg::xlen-1:0]       fe_pc;

    ////////////////////
    // decode to execute
    logic                           de_valid;
    logic [cpu_pkg::xlen-1:0]       de_pc;
    logic [cpu_pkg::opcode_w-1:0]   de_op;
    logic                           de_use_imm;
    logic [cpu_pkg::xlen-1:0]       de_imm;
    logic [cpu_pkg::reg_addr_w-1:0] de_rs1;
    logic [cpu_pkg::reg_addr_w-1:0] de_rs2;
    logic [cpu_pkg::xlen-1:0]       de_rs1_data;
    logic [cpu_pkg::xlen-1:0]       de_rs2_data;
    logic                           de_wr_en;
    logic [cpu_pkg::reg_addr_w-1:0] de_rd;

    ////////////////////
    // writeback register
    logic [cpu_pkg::xlen-1:0]       ex_pc;
    logic                           ex_wr_en;
    logic [cpu_pkg::reg_addr_w-1:0] ex_rd;
    logic [cpu_pkg::xlen-1:0]       ex_data;

    fetch i_fetch (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .fe_valid    (fe_valid),
        .fe_instr    (fe_instr),
        .fe_pc       (fe_pc)
    );

    // writeback register loops back into the register file
    decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .fe_valid    (fe_valid),
        .fe_instr    (fe_instr),
        .fe_pc       (fe_pc),
        .wb_en       (ex_wr_en),
        .wb_addr     (ex_rd),
        .wb_data     (ex_data),
        .de_valid    (de_valid),
        .de_pc       (de_pc),
        .de_op       (de_op),
        .de_use_imm  (de_use_imm),
        .de_imm      (de_imm),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_rs1_data (de_rs1_data),
        .de_rs2_data (de_rs2_data),
        .de_wr_en    (de_wr_en),
        .de_rd       (de_rd)
    );

    execute i_execute (
        .clk         (clk),
        .reset       (reset),
        .de_valid    (de_valid),
        .de_pc       (de_pc),
        .de_op       (de_op),
        .de_use_imm  (de_use_imm),
        .de_imm      (de_imm),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_rs1_data (de_rs1_data),
        .de_rs2_data (de_rs2_data),
        .de_wr_en    (de_wr_en),
        .de_rd       (de_rd),
        .ex_valid    (),
        .ex_pc       (ex_pc),
        .ex_wr_en    (ex_wr_en),
        .ex_rd       (ex_rd),
        .ex_data     (ex_data)
    );

    // retire port is the writeback register as is
    assign wb_valid = ex_wr_en;
    assign wb_pc    = ex_pc;
    assign wb_rd    = ex_rd;
    assign wb_data  = ex_data;

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////
    // widths

    // data path and pc
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int opcode_w   = 5;
    localparam int imm_w      = 17;
    // shift amount comes from the low bits of operand b
    localparam int shamt_w    = $clog2(xlen);
    // spare low bits of the register format
    localparam int r_pad_w    = xlen - opcode_w - 3 * reg_addr_w;

    // one word per accepted instruction
    localparam logic [xlen-1:0] pc_step = xlen'(4);

    ////////////////////
    // opcodes

    // register format
    localparam logic [opcode_w-1:0] op_add  = 5'h01;
    localparam logic [opcode_w-1:0] op_sub  = 5'h02;
    localparam logic [opcode_w-1:0] op_and  = 5'h03;
    localparam logic [opcode_w-1:0] op_or   = 5'h04;
    localparam logic [opcode_w-1:0] op_xor  = 5'h05;
    localparam logic [opcode_w-1:0] op_shl  = 5'h06;
    localparam logic [opcode_w-1:0] op_shr  = 5'h07;
    // immediate format
    localparam logic [opcode_w-1:0] op_addi = 5'h08;
    localparam logic [opcode_w-1:0] op_ori  = 5'h09;
    // anything else is illegal, 5'h00 included

    ////////////////////
    // instruction word

    // opcode, rd, rs1 sit in the same place in both views
    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [r_pad_w-1:0]    pad;
    } r_fmt_t;

    // rs2 slot and pad bits become a signed immediate
    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [imm_w-1:0]      imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

endpackage

`default_nettype wire

// File: decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             fe_valid,
    input  wire [cpu_pkg::xlen-1:0]         fe_instr,
    input  wire [cpu_pkg::xlen-1:0]         fe_pc,
    input  wire                             wb_en,
    input  wire [cpu_pkg::reg_addr_w-1:0]   wb_addr,
    input  wire [cpu_pkg::xlen-1:0]         wb_data,
    output logic                            de_valid,
    output logic [cpu_pkg::xlen-1:0]        de_pc,
    output logic [cpu_pkg::opcode_w-1:0]    de_op,
    output logic                            de_use_imm,
    output logic [cpu_pkg::xlen-1:0]        de_imm,
    output logic [cpu_pkg::reg_addr_w-1:0]  de_rs1,
    output logic [cpu_pkg::reg_addr_w-1:0]  de_rs2,
    output logic [cpu_pkg::xlen-1:0]        de_rs1_data,
    output logic [cpu_pkg::xlen-1:0]        de_rs2_data,
    output logic                            de_wr_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  de_rd
);

    cpu_pkg::instr_t                 instr_w;
    logic [cpu_pkg::opcode_w-1:0]    opcode;
    logic [cpu_pkg::reg_addr_w-1:0]  rd;
    logic [cpu_pkg::reg_addr_w-1:0]  rs1;
    logic [cpu_pkg::reg_addr_w-1:0]  rs2;
    logic [cpu_pkg::xlen-1:0]        imm;
    logic [cpu_pkg::xlen-1:0]        rs1_data;
    logic [cpu_pkg::xlen-1:0]        rs2_data;
    logic                            legal;
    logic                            use_imm;
    logic                            wr_en;

    ////////////////////
    // field extraction

    // shared fields, same bits in either view
    assign instr_w = fe_instr;
    assign opcode  = instr_w.r_fmt.opcode;
    assign rd      = instr_w.r_fmt.rd;
    assign rs1     = instr_w.r_fmt.rs1;

    // opcode picks the view
    always_comb begin
        legal   = 1'b1;
        use_imm = 1'b0;
        case (opcode)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
            cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_shl,
            cpu_pkg::op_shr: use_imm = 1'b0;
            cpu_pkg::op_addi, cpu_pkg::op_ori: use_imm = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    // imm view has no rs2, park it on r0 so nothing forwards
    assign rs2 = use_imm ? '0 : instr_w.r_fmt.rs2;
    // sign extend
    assign imm = {{(cpu_pkg::xlen - cpu_pkg::imm_w){instr_w.i_fmt.imm[cpu_pkg::imm_w-1]}},
                  instr_w.i_fmt.imm};
    // illegal or rd 0 retires silently
    assign wr_en = fe_valid && legal && (rd != '0);

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wr_en    (wb_en),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    ////////////////////
    // decode to execute register

    always_ff @(posedge clk) begin
        if (reset) begin
            de_valid <= 1'b0;
            de_wr_en <= 1'b0;
        end else begin
            de_valid <= fe_valid;
            de_wr_en <= wr_en;
        end
    end

    // payload only loads with a live instruction
    always_ff @(posedge clk) begin
        if (fe_valid) begin
            de_pc       <= fe_pc;
            de_op       <= opcode;
            de_use_imm  <= use_imm;
            de_imm      <= imm;
            de_rs1      <= rs1;
            de_rs2      <= rs2;
            de_rs1_data <= rs1_data;
            de_rs2_data <= rs2_data;
            de_rd       <= rd;
        end
    end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             de_valid,
    input  wire [cpu_pkg::xlen-1:0]         de_pc,
    input  wire [cpu_pkg::opcode_w-1:0]     de_op,
    input  wire                             de_use_imm,
    input  wire [cpu_pkg::xlen-1:0]         de_imm,
    input  wire [cpu_pkg::reg_addr_w-1:0]   de_rs1,
    input  wire [cpu_pkg::reg_addr_w-1:0]   de_rs2,
    input  wire [cpu_pkg::xlen-1:0]         de_rs1_data,
    input  wire [cpu_pkg::xlen-1:0]         de_rs2_data,
    input  wire                             de_wr_en,
    input  wire [cpu_pkg::reg_addr_w-1:0]   de_rd,
    output logic                            ex_valid,
    output logic [cpu_pkg::xlen-1:0]        ex_pc,
    output logic                            ex_wr_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  ex_rd,
    output logic [cpu_pkg::xlen-1:0]        ex_data
);

    logic                     fwd1;
    logic                     fwd2;
    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b_reg;
    logic [cpu_pkg::xlen-1:0] op_b;
    logic [cpu_pkg::xlen-1:0] alu_out;

    forwarding i_forwarding (
        .de_rs1   (de_rs1),
        .de_rs2   (de_rs2),
        .ex_wr_en (ex_wr_en),
        .ex_rd    (ex_rd),
        .fwd1     (fwd1),
        .fwd2     (fwd2)
    );

    ////////////////////
    // operand muxes

    // previous result wins over the decode-time read
    assign op_a     = fwd1 ? ex_data : de_rs1_data;
    assign op_b_reg = fwd2 ? ex_data : de_rs2_data;
    assign op_b     = de_use_imm ? de_imm : op_b_reg;

    ////////////////////
    // alu

    always_comb begin
        case (de_op)
            cpu_pkg::op_add,
            cpu_pkg::op_addi: alu_out = op_a + op_b;
            cpu_pkg::op_sub:  alu_out = op_a - op_b;
            cpu_pkg::op_and:  alu_out = op_a & op_b;
            cpu_pkg::op_or,
            cpu_pkg::op_ori:  alu_out = op_a | op_b;
            cpu_pkg::op_xor:  alu_out = op_a ^ op_b;
            // logical shifts, amount from low bits of b
            cpu_pkg::op_shl:  alu_out = op_a << op_b[cpu_pkg::shamt_w-1:0];
            cpu_pkg::op_shr:  alu_out = op_a >> op_b[cpu_pkg::shamt_w-1:0];
            // illegal, wr_en is already low
            default:          alu_out = '0;
        endcase
    end

    ////////////////////
    // writeback register

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_wr_en <= 1'b0;
        end else begin
            ex_valid <= de_valid;
            ex_wr_en <= de_valid && de_wr_en;
        end
    end

    // result and tag, held across bubbles
    always_ff @(posedge clk) begin
        if (de_valid) begin
            ex_pc   <= de_pc;
            ex_rd   <= de_rd;
            ex_data <= alu_out;
        end
    end

    // a forward needs a live write from a nonzero rd
    a_fwd_needs_write: assert property (@(posedge clk) disable iff (reset)
        (fwd1 || fwd2) |-> (ex_wr_en && (ex_rd != '0)))
        else $error("execute: forward selected without a pending write");

endmodule

`default_nettype wire

// File: fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      instr_valid,
    input  wire [cpu_pkg::xlen-1:0]  instr,
    output logic                     fe_valid,
    output logic [cpu_pkg::xlen-1:0] fe_instr,
    output logic [cpu_pkg::xlen-1:0] fe_pc
);

    // address the next accepted word gets
    logic [cpu_pkg::xlen-1:0] pc;

    // valid follows the strobe one cycle later
    // pc only moves on an accepted word
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            fe_valid <= 1'b0;
            fe_pc    <= '0;
        end else begin
            fe_valid <= instr_valid;
            if (instr_valid) begin
                fe_pc <= pc;
                pc    <= pc + cpu_pkg::pc_step;
            end
        end
    end

    // capture register for the word itself
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fe_instr <= instr;
        end
    end

    // a live slot carries a known word and pc once out of reset
    a_fe_pc_known: assert property (@(posedge clk) disable iff (reset)
        fe_valid |-> !$isunknown({fe_instr, fe_pc}))
        else $error("fetch: unknown word or pc in a live slot");

endmodule

`default_nettype wire

// File: filelist.f
cpu_pkg.sv
fetch.sv
register_file.sv
decode.sv
forwarding.sv
execute.sv
cpu.sv
tb_cpu.sv

// File: forwarding.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding (
    input  wire [cpu_pkg::reg_addr_w-1:0] de_rs1,
    input  wire [cpu_pkg::reg_addr_w-1:0] de_rs2,
    input  wire                           ex_wr_en,
    input  wire [cpu_pkg::reg_addr_w-1:0] ex_rd,
    output logic                          fwd1,
    output logic                          fwd2
);

    // only one producer stage to look at
    // older results come through the register file bypass
    function automatic logic hit(
        input logic                           en,
        input logic [cpu_pkg::reg_addr_w-1:0] dst,
        input logic [cpu_pkg::reg_addr_w-1:0] src
    );
        // rd 0 already has en low, no extra zero check
        return en && (dst == src);
    endfunction

    ////////////////////
    // operand selects

    // operand a
    assign fwd1 = hit(ex_wr_en, ex_rd, de_rs1);
    // operand b, rs2 is r0 for imm format
    assign fwd2 = hit(ex_wr_en, ex_rd, de_rs2);

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [cpu_pkg::reg_addr_w-1:0]  rs1,
    input  wire [cpu_pkg::reg_addr_w-1:0]  rs2,
    input  wire                            wr_en,
    input  wire [cpu_pkg::reg_addr_w-1:0]  wr_addr,
    input  wire [cpu_pkg::xlen-1:0]        wr_data,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data
);

    logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::num_regs];

    ////////////////////
    // write port

    // entry 0 is never written, decode drops rd 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // read ports

    // zero reg first, then same-cycle write, then array
    // the bypass covers a producer two slots ahead
    function automatic logic [cpu_pkg::xlen-1:0] read_port(
        input logic [cpu_pkg::reg_addr_w-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wr_en && (addr == wr_addr)) begin
            return wr_data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    // decode must have cleared the write enable for rd 0
    a_no_zero_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (wr_addr != '0))
        else $error("register_file: write addressed to register 0");

endmodule

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    logic                           clk;
    logic                           reset;
    logic                           instr_valid;
    logic [cpu_pkg::xlen-1:0]       instr;
    logic                           wb_valid;
    logic [cpu_pkg::xlen-1:0]       wb_pc;
    logic [cpu_pkg::reg_addr_w-1:0] wb_rd;
    logic [cpu_pkg::xlen-1:0]       wb_data;

    ////////////////////
    // test table

    // one row per test, instructions stored flat
    string                    names[$];
    int                       first[$];
    int                       count[$];
    // retirements a test must produce, -1 for random
    int                       exp_wb[$];
    logic [cpu_pkg::xlen-1:0] prog[$];
    // idle cycles after each instruction
    int                       gaps[$];

    ////////////////////
    // golden model

    logic [cpu_pkg::xlen-1:0]       gold [cpu_pkg::num_regs];
    logic [cpu_pkg::xlen-1:0]       gold_pc;
    // expected retirements, oldest first
    logic [cpu_pkg::xlen-1:0]       q_pc[$];
    logic [cpu_pkg::reg_addr_w-1:0] q_rd[$];
    logic [cpu_pkg::xlen-1:0]       q_data[$];
    int                             q_cyc[$];

    int cyc;
    int cur_test;
    int errors;
    int checks;
    int retired;
    int seed;
    bit built;

    cpu DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // edge counter for the latency check
    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////
    // instruction builders

    function automatic logic [cpu_pkg::xlen-1:0] r_word(input logic [4:0] op, input int rd,
                                                         input int rs1, input int rs2);
        cpu_pkg::instr_t w;
        w.r_fmt.opcode = op;
        w.r_fmt.rd     = rd[4:0];
        w.r_fmt.rs1    = rs1[4:0];
        w.r_fmt.rs2    = rs2[4:0];
        w.r_fmt.pad    = '0;
        return w;
    endfunction

    function automatic logic [cpu_pkg::xlen-1:0] i_word(input logic [4:0] op, input int rd,
                                                         input int rs1, input int imm);
        cpu_pkg::instr_t w;
        w.i_fmt.opcode = op;
        w.i_fmt.rd     = rd[4:0];
        w.i_fmt.rs1    = rs1[4:0];
        w.i_fmt.imm    = imm[cpu_pkg::imm_w-1:0];
        return w;
    endfunction

    // the nine legal opcodes by index
    function automatic logic [4:0] legal_op(input int idx);
        case (idx)
            0: return cpu_pkg::op_add;
            1: return cpu_pkg::op_sub;
            2: return cpu_pkg::op_and;
            3: return cpu_pkg::op_or;
            4: return cpu_pkg::op_xor;
            5: return cpu_pkg::op_shl;
            6: return cpu_pkg::op_shr;
            7: return cpu_pkg::op_addi;
            default: return cpu_pkg::op_ori;
        endcase
    endfunction

    task automatic open_test(input string name, input int retires);
        names.push_back(name);
        first.push_back(prog.size());
        exp_wb.push_back(retires);
    endtask

    task automatic close_test();
        count.push_back(prog.size() - first[first.size()-1]);
    endtask

    task automatic add_instr(input logic [cpu_pkg::xlen-1:0] word, input int gap);
        prog.push_back(word);
        gaps.push_back(gap);
    endtask

    task automatic build_table();
        int                r;
        logic [4:0]        op;
        open_test("alu_ops", 11);
        add_instr(i_word(cpu_pkg::op_addi, 1, 0, 100), 0);
        add_instr(i_word(cpu_pkg::op_addi, 2, 0, -7), 0);
        add_instr(r_word(cpu_pkg::op_add, 3, 1, 2), 0);
        add_instr(r_word(cpu_pkg::op_sub, 4, 1, 2), 0);
        add_instr(r_word(cpu_pkg::op_and, 5, 1, 2), 0);
        add_instr(r_word(cpu_pkg::op_or, 6, 1, 2), 0);
        add_instr(r_word(cpu_pkg::op_xor, 7, 1, 2), 0);
        // shift by 25, low bits of -7
        add_instr(r_word(cpu_pkg::op_shl, 8, 1, 2), 0);
        add_instr(r_word(cpu_pkg::op_shr, 9, 2, 1), 0);
        add_instr(i_word(cpu_pkg::op_ori, 10, 1, -4096), 0);
        // most negative immediate
        add_instr(i_word(cpu_pkg::op_addi, 23, 2, -65536), 0);
        close_test();
        open_test("forward_distance", 13);
        add_instr(i_word(cpu_pkg::op_addi, 11, 0, 5), 0);
        // distance 1
        add_instr(i_word(cpu_pkg::op_addi, 11, 11, 3), 0);
        add_instr(r_word(cpu_pkg::op_add, 12, 11, 11), 0);
        // distance 2, through the register file bypass
        add_instr(i_word(cpu_pkg::op_addi, 13, 0, 9), 0);
        add_instr(i_word(cpu_pkg::op_addi, 20, 0, 1), 0);
        add_instr(r_word(cpu_pkg::op_sub, 14, 0, 13), 0);
        // distance 3, plain read
        add_instr(i_word(cpu_pkg::op_addi, 15, 0, 7), 0);
        add_instr(i_word(cpu_pkg::op_addi, 21, 0, 1), 0);
        add_instr(i_word(cpu_pkg::op_addi, 22, 0, 1), 0);
        add_instr(r_word(cpu_pkg::op_xor, 16, 15, 11), 0);
        // distance counted in cycles with bubbles between
        add_instr(i_word(cpu_pkg::op_addi, 24, 0, 12), 1);
        add_instr(i_word(cpu_pkg::op_addi, 24, 24, 1), 2);
        add_instr(r_word(cpu_pkg::op_or, 25, 24, 0), 0);
        close_test();
        open_test("zero_register", 3);
        add_instr(i_word(cpu_pkg::op_addi, 0, 0, 55), 0);
        add_instr(r_word(cpu_pkg::op_add, 17, 0, 0), 0);
        add_instr(i_word(cpu_pkg::op_ori, 0, 1, 1), 0);
        add_instr(i_word(cpu_pkg::op_addi, 18, 0, -1), 0);
        add_instr(r_word(cpu_pkg::op_add, 19, 0, 18), 0);
        close_test();
        open_test("illegal_opcode", 2);
        add_instr(r_word(5'h00, 5, 1, 2), 0);
        add_instr(r_word(5'h1f, 6, 1, 2), 1);
        add_instr(i_word(cpu_pkg::op_addi, 27, 0, 3), 0);
        // illegal aimed at a live register, no write allowed
        add_instr(r_word(5'h0a, 27, 27, 27), 0);
        add_instr(r_word(cpu_pkg::op_add, 28, 27, 0), 0);
        close_test();
        open_test("random_mix", -1);
        for (int i = 0; i < 40; i++) begin
            r = $unsigned($random(seed)) % 12;
            // upper opcode half is never legal
            op = (r < 9) ? legal_op(r) : (5'h10 | r[4:0]);
            if (op == cpu_pkg::op_addi || op == cpu_pkg::op_ori) begin
                add_instr(i_word(op, $unsigned($random(seed)) % 8,
                                 $unsigned($random(seed)) % 8, $random(seed)),
                          $unsigned($random(seed)) % 3);
            end else begin
                // few registers so dependencies are common
                add_instr(r_word(op, $unsigned($random(seed)) % 8,
                                 $unsigned($random(seed)) % 8,
                                 $unsigned($random(seed)) % 8),
                          $unsigned($random(seed)) % 3);
            end
        end
        close_test();
    endtask

    ////////////////////
    // reference model

    // program order update, pc moves by 4 for every instruction
    task automatic model_step(input logic [cpu_pkg::xlen-1:0] word, input int when);
        cpu_pkg::instr_t          w;
        logic signed [16:0]       simm;
        logic signed [31:0]       imm32;
        logic [cpu_pkg::xlen-1:0] a;
        logic [cpu_pkg::xlen-1:0] b;
        logic [cpu_pkg::xlen-1:0] res;
        logic                     legal;
        w     = word;
        simm  = w.i_fmt.imm;
        imm32 = simm;
        a     = gold[w.r_fmt.rs1];
        b     = gold[w.r_fmt.rs2];
        legal = 1'b1;
        res   = '0;
        case (w.r_fmt.opcode)
            cpu_pkg::op_add:  res = a + b;
            cpu_pkg::op_sub:  res = a - b;
            cpu_pkg::op_and:  res = a & b;
            cpu_pkg::op_or:   res = a | b;
            cpu_pkg::op_xor:  res = a ^ b;
            cpu_pkg::op_shl:  res = a << b[4:0];
            cpu_pkg::op_shr:  res = a >> b[4:0];
            cpu_pkg::op_addi: res = a + imm32;
            cpu_pkg::op_ori:  res = a | imm32;
            default:          legal = 1'b0;
        endcase
        if (legal && w.r_fmt.rd != 0) begin
            gold[w.r_fmt.rd] = res;
            q_pc.push_back(gold_pc);
            q_rd.push_back(w.r_fmt.rd);
            q_data.push_back(res);
            q_cyc.push_back(when);
        end
        gold_pc = gold_pc + 4;
    endtask

    ////////////////////
    // retire monitor

    task automatic check_value(input string what, input logic [31:0] expv,
                               input logic [31:0] act);
        checks++;
        if (expv !== act) begin
            $display("FAIL %s %s: expected 0x%h actual 0x%h", names[cur_test], what, expv, act);
            errors++;
        end
    endtask

    // outputs settle after the edge, sample mid cycle
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            retired++;
            if (q_pc.size() == 0) begin
                $display("%s: wb_valid high with no instruction pending, cycle %0d",
                         names[cur_test], cyc);
                errors++;
            end else begin
                check_value("wb_pc", q_pc.pop_front(), wb_pc);
                check_value("wb_rd", q_rd.pop_front(), wb_rd);
                check_value("wb_data", q_data.pop_front(), wb_data);
                check_value("retire cycle", q_cyc.pop_front(), cyc);
            end
        end
    end

    ////////////////////
    // test runner

    task automatic run_test(input int t);
        int err_before;
        int ret_before;
        err_before = errors;
        ret_before = retired;
        cur_test   = t;
        for (int i = first[t]; i < first[t] + count[t]; i++) begin
            instr_valid = 1'b1;
            instr       = prog[i];
            // sampled at the next edge, result visible two edges later
            model_step(prog[i], cyc + 3);
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            repeat (gaps[i]) begin
                @(posedge clk);
                #1;
            end
        end
        while (q_pc.size() != 0) @(posedge clk);
        // a stray retire still lands in this test
        repeat (3) @(posedge clk);
        #1;
        if (exp_wb[t] >= 0 && retired - ret_before != exp_wb[t]) begin
            $display("FAIL %s retire count: expected %0d actual %0d",
                     names[t], exp_wb[t], retired - ret_before);
            errors++;
        end
        $display("%s: %0d instructions, %0d retired, %0d errors",
                 names[t], count[t], retired - ret_before, errors - err_before);
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 48;
        errors      = 0;
        checks      = 0;
        retired     = 0;
        cur_test    = 0;
        gold_pc     = '0;
        for (int i = 0; i < cpu_pkg::num_regs; i++) begin
            gold[i] = '0;
        end
        build_table();
        built = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        // quiet pipeline, no retire expected yet
        repeat (3) @(posedge clk);
        #1;
        for (int t = 0; t < names.size(); t++) begin
            run_test(t);
        end
        $display("tests %0d, checks %0d, errors %0d", names.size(), checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog, scaled by table size
    initial begin
        int budget;
        int gap_total;
        wait (built);
        gap_total = 0;
        foreach (gaps[i]) gap_total += gaps[i];
        budget = 19 + names.size() * (prog.size() + gap_total + 10);
        repeat (budget) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", budget);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
